// ==== hdl/issue_pkg.sv ====
package issue_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////////////////////////

  localparam int INST_W      = 32;
  localparam int ADDR_W      = 32;
  localparam int ID_W        = 8;
  localparam int REG_W       = 5;
  localparam int OPC_W       = 6;
  localparam int QUEUE_DEPTH = 4;                     // pair entries.
  localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
  localparam int PIPE_W      = 2;

  // pipe classes.
  localparam logic [PIPE_W-1:0] PIPE_NONE   = 2'd0;
  localparam logic [PIPE_W-1:0] PIPE_ALU    = 2'd1;
  localparam logic [PIPE_W-1:0] PIPE_BRANCH = 2'd2;
  localparam logic [PIPE_W-1:0] PIPE_MEMORY = 2'd3;

  //////////////////////////////////////////////////////////////////////
  // opcodes
  //////////////////////////////////////////////////////////////////////

  localparam logic [OPC_W-1:0] OPC_NOP   = 6'b000000;
  localparam logic [OPC_W-1:0] OPC_CMP   = 6'b001000;   // 00 group.
  localparam logic [OPC_W-1:0] OPC_TEST  = 6'b001001;
  localparam logic [OPC_W-1:0] OPC_CMPI  = 6'b011000;   // 01 group.
  localparam logic [OPC_W-1:0] OPC_TESTI = 6'b011001;
  localparam logic [OPC_W-1:0] OPC_LW    = 6'b100000;   // memory group.
  localparam logic [OPC_W-1:0] OPC_SW    = 6'b100001;
  localparam logic [OPC_W-1:0] OPC_LA    = 6'b100010;
  localparam logic [OPC_W-1:0] OPC_SA    = 6'b100011;
  localparam logic [OPC_W-1:0] OPC_JR    = 6'b110000;   // jump group.

  // one instruction word, register or immediate format.
  typedef union packed {
    struct packed {
      logic [OPC_W-1:0] opcode;
      logic [REG_W-1:0] rs;
      logic [REG_W-1:0] rt;
      logic [REG_W-1:0] rd;
      logic [10:0]      low;
    } r_fmt;
    struct packed {
      logic [OPC_W-1:0] opcode;
      logic [REG_W-1:0] rs;
      logic [REG_W-1:0] rt;
      logic [15:0]      imm;
    } i_fmt;
  } inst_u;

  // also marks an empty lane.
  localparam inst_u NOP_WORD = inst_u'({INST_W{1'b0}});

endpackage

// ==== hdl/issue_if.sv ====
interface lane_if import issue_pkg::*; ();

  logic              valid;
  inst_u             inst;
  logic [ADDR_W-1:0] pc;
  logic [ID_W-1:0]   id;

  modport source (output valid, output inst, output pc, output id);
  modport decode (input valid, input inst);
  modport issue  (input valid, input inst, input pc, input id);

endinterface

interface decode_if import issue_pkg::*; ();

  logic              rs_used;
  logic              rt_used;
  logic              dst_valid;
  logic [REG_W-1:0]  dst_reg;
  logic [PIPE_W-1:0] pipe;
  logic              load_hazard;

  modport result (output rs_used, output rt_used, output dst_valid,
                  output dst_reg, output pipe, output load_hazard);
  modport issue  (input rs_used, input rt_used, input dst_valid,
                  input dst_reg, input pipe, input load_hazard);

endinterface

// ==== hdl/pair_fetch_queue.sv ====
module pair_fetch_queue import issue_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  output logic              in_ready,
  input  inst_u             in_inst0,
  input  inst_u             in_inst1,
  input  logic [ADDR_W-1:0] in_pc0,
  input  logic [ADDR_W-1:0] in_pc1,
  input  logic [ID_W-1:0]   in_id0,
  input  logic [ID_W-1:0]   in_id1,
  input  logic              take0,
  input  logic              take1,
  lane_if.source            lane0,
  lane_if.source            lane1
);

  inst_u             inst0_q [QUEUE_DEPTH];
  inst_u             inst1_q [QUEUE_DEPTH];
  logic [ADDR_W-1:0] pc0_q   [QUEUE_DEPTH];
  logic [ADDR_W-1:0] pc1_q   [QUEUE_DEPTH];
  logic [ID_W-1:0]   id0_q   [QUEUE_DEPTH];
  logic [ID_W-1:0]   id1_q   [QUEUE_DEPTH];

  logic [QPTR_W-1:0] wr_ptr;
  logic [QPTR_W-1:0] rd_ptr;
  logic [QPTR_W:0]   count;
  logic [QPTR_W:0]   count_seen;    // entries old enough to read.
  logic              lane0_done;    // leftover in lane 1.
  logic              head_vis;
  logic              push;
  logic              pop;
  logic              left0;
  logic              left1;

  assign in_ready = (count != (QPTR_W + 1)'(QUEUE_DEPTH));
  assign push     = in_valid && in_ready;
  assign head_vis = (count_seen != '0);

  //////////////////////////////////////////////////////////////////////
  // head presentation
  //////////////////////////////////////////////////////////////////////

  assign lane0.valid = head_vis && !lane0_done && (inst0_q[rd_ptr] != NOP_WORD);
  assign lane0.inst  = inst0_q[rd_ptr];
  assign lane0.pc    = pc0_q[rd_ptr];
  assign lane0.id    = id0_q[rd_ptr];

  assign lane1.valid = head_vis && (inst1_q[rd_ptr] != NOP_WORD);
  assign lane1.inst  = inst1_q[rd_ptr];
  assign lane1.pc    = pc1_q[rd_ptr];
  assign lane1.id    = id1_q[rd_ptr];

  // pop once nothing valid is left in the head.
  assign left0 = lane0.valid && !take0;
  assign left1 = lane1.valid && !take1;
  assign pop   = head_vis && !left0 && !left1;

  always_ff @(posedge clk) begin
    if (push) begin
      inst0_q[wr_ptr] <= in_inst0;
      inst1_q[wr_ptr] <= in_inst1;
      pc0_q[wr_ptr]   <= in_pc0;
      pc1_q[wr_ptr]   <= in_pc1;
      id0_q[wr_ptr]   <= in_id0;
      id1_q[wr_ptr]   <= in_id1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      count_seen <= '0;
      lane0_done <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr     <= rd_ptr + 1'b1;
        lane0_done <= 1'b0;
      end else if (take0) begin
        lane0_done <= 1'b1;           // older one gone, younger stays.
      end
      count      <= count + (QPTR_W + 1)'(push) - (QPTR_W + 1)'(pop);
      count_seen <= count - (QPTR_W + 1)'(pop);  // new entries show a cycle later.
    end
  end

endmodule

// ==== hdl/lane_decoder.sv ====
module lane_decoder import issue_pkg::*; (
  lane_if.decode          lane,
  input logic             ex_load_valid,
  input logic [REG_W-1:0] ex_load_rt,
  decode_if.result        info
);

  logic [OPC_W-1:0]  opc;
  logic [REG_W-1:0]  rs;
  logic [REG_W-1:0]  rt;
  logic              rs_used;
  logic              rt_used;
  logic              dst_valid;
  logic [REG_W-1:0]  dst_reg;
  logic [PIPE_W-1:0] pipe;

  assign opc = lane.inst.i_fmt.opcode;
  assign rs  = lane.inst.i_fmt.rs;
  assign rt  = lane.inst.i_fmt.rt;

  always_comb begin
    rs_used   = 1'b0;
    rt_used   = 1'b0;
    dst_valid = 1'b0;
    dst_reg   = rt;
    pipe      = PIPE_NONE;
    if (lane.valid && opc != OPC_NOP) begin
      case (opc[OPC_W-1:OPC_W-2])
        2'b00: begin                        // register alu ops.
          rs_used   = 1'b1;
          rt_used   = 1'b1;
          dst_valid = 1'b1;
          dst_reg   = lane.inst.r_fmt.rd;
          pipe      = (opc == OPC_CMP || opc == OPC_TEST) ? PIPE_BRANCH : PIPE_ALU;
        end
        2'b01: begin                        // immediate alu ops.
          rs_used   = 1'b1;
          dst_valid = 1'b1;
          pipe      = (opc == OPC_CMPI || opc == OPC_TESTI) ? PIPE_BRANCH : PIPE_ALU;
        end
        2'b10: begin
          pipe      = PIPE_MEMORY;
          rs_used   = (opc == OPC_LW) || (opc == OPC_SW);
          rt_used   = (opc == OPC_SW) || (opc == OPC_SA);
          dst_valid = (opc == OPC_LW) || (opc == OPC_LA);
        end
        default: begin                      // jumps.
          pipe      = PIPE_BRANCH;
          rs_used   = (opc == OPC_JR);
        end
      endcase
    end
  end

  assign info.rs_used     = rs_used;
  assign info.rt_used     = rt_used;
  assign info.dst_valid   = dst_valid;
  assign info.dst_reg     = dst_reg;
  assign info.pipe        = pipe;
  assign info.load_hazard = ex_load_valid &&
                            ((rs_used && rs == ex_load_rt) || (rt_used && rt == ex_load_rt));

endmodule

// ==== hdl/pair_issue_ctrl.sv ====
module pair_issue_ctrl import issue_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  lane_if.issue             lane0,
  lane_if.issue             lane1,
  decode_if.issue           info0,
  decode_if.issue           info1,
  output logic              take0,
  output logic              take1,
  output logic              issue_valid,
  input  logic              issue_ready,
  output logic              slot0_valid,
  output logic              slot1_valid,
  output inst_u             slot0_inst,
  output inst_u             slot1_inst,
  output logic [ADDR_W-1:0] slot0_pc,
  output logic [ADDR_W-1:0] slot1_pc,
  output logic [ID_W-1:0]   slot0_id,
  output logic [ID_W-1:0]   slot1_id,
  output logic              swapped
);

  logic load_en;
  logic hazard;
  logic both;
  logic dep;
  logic conflict;
  logic go0;
  logic go1;
  logic lone_mem;
  logic n_s0_valid;
  logic n_s1_valid;
  logic n_swapped;
  logic s0_from1;
  logic s1_from1;

  //////////////////////////////////////////////////////////////////////
  // issue decision
  //////////////////////////////////////////////////////////////////////

  assign load_en = !issue_valid || issue_ready;
  assign hazard  = info0.load_hazard || info1.load_hazard;
  assign both    = lane0.valid && lane1.valid;

  // younger reads what the older writes.
  assign dep = both && info0.dst_valid &&
               ((info1.rs_used && lane1.inst.i_fmt.rs == info0.dst_reg) ||
                (info1.rt_used && lane1.inst.i_fmt.rt == info0.dst_reg));

  assign conflict = both && (info0.pipe == info1.pipe) &&
                    (info0.pipe == PIPE_BRANCH || info0.pipe == PIPE_MEMORY);

  assign go0   = !hazard && lane0.valid;
  assign go1   = !hazard && lane1.valid && !dep && !conflict;
  assign take0 = load_en && go0;
  assign take1 = load_en && go1;

  assign lone_mem = go0 ? (info0.pipe == PIPE_MEMORY) : (info1.pipe == PIPE_MEMORY);

  // slot steering.
  always_comb begin
    n_s0_valid = 1'b0;
    n_s1_valid = 1'b0;
    n_swapped  = 1'b0;
    s0_from1   = 1'b0;
    s1_from1   = 1'b1;
    if (go0 && go1) begin
      n_swapped  = (info0.pipe == PIPE_MEMORY) || (info1.pipe == PIPE_BRANCH);
      n_s0_valid = 1'b1;
      n_s1_valid = 1'b1;
      s0_from1   = n_swapped;
      s1_from1   = !n_swapped;
    end else if (go0 || go1) begin
      n_s0_valid = !lone_mem;         // memory unit sits in slot 1.
      n_s1_valid = lone_mem;
      s0_from1   = go1;
      s1_from1   = go1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // issue register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      slot0_valid <= 1'b0;
      slot1_valid <= 1'b0;
      swapped     <= 1'b0;
    end else if (load_en) begin
      slot0_valid <= n_s0_valid;
      slot1_valid <= n_s1_valid;
      swapped     <= n_swapped;
    end
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      slot0_inst <= !n_s0_valid ? NOP_WORD : (s0_from1 ? lane1.inst : lane0.inst);
      slot0_pc   <= !n_s0_valid ? '0 : (s0_from1 ? lane1.pc : lane0.pc);
      slot0_id   <= !n_s0_valid ? '0 : (s0_from1 ? lane1.id : lane0.id);
      slot1_inst <= !n_s1_valid ? NOP_WORD : (s1_from1 ? lane1.inst : lane0.inst);
      slot1_pc   <= !n_s1_valid ? '0 : (s1_from1 ? lane1.pc : lane0.pc);
      slot1_id   <= !n_s1_valid ? '0 : (s1_from1 ? lane1.id : lane0.id);
    end
  end

  assign issue_valid = slot0_valid || slot1_valid;

endmodule

// ==== hdl/dual_issue_stage.sv ====
module dual_issue_stage import issue_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              in_valid,
  output logic              in_ready,
  input  inst_u             in_inst0,
  input  inst_u             in_inst1,
  input  logic [ADDR_W-1:0] in_pc0,
  input  logic [ADDR_W-1:0] in_pc1,
  input  logic [ID_W-1:0]   in_id0,
  input  logic [ID_W-1:0]   in_id1,
  input  logic              ex_load_valid,
  input  logic [REG_W-1:0]  ex_load_rt,
  output logic              issue_valid,
  input  logic              issue_ready,
  output logic              slot0_valid,
  output logic              slot1_valid,
  output inst_u             slot0_inst,
  output inst_u             slot1_inst,
  output logic [ADDR_W-1:0] slot0_pc,
  output logic [ADDR_W-1:0] slot1_pc,
  output logic [ID_W-1:0]   slot0_id,
  output logic [ID_W-1:0]   slot1_id,
  output logic              swapped
);

  logic take0;
  logic take1;

  lane_if   lane [2] ();
  decode_if info [2] ();

  pair_fetch_queue u_queue (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_inst0 (in_inst0),
    .in_inst1 (in_inst1),
    .in_pc0   (in_pc0),
    .in_pc1   (in_pc1),
    .in_id0   (in_id0),
    .in_id1   (in_id1),
    .take0    (take0),
    .take1    (take1),
    .lane0    (lane[0]),
    .lane1    (lane[1])
  );

  // one decoder per lane.
  for (genvar g = 0; g < 2; g++) begin : g_dec
    lane_decoder u_dec (
      .lane          (lane[g]),
      .ex_load_valid (ex_load_valid),
      .ex_load_rt    (ex_load_rt),
      .info          (info[g])
    );
  end

  pair_issue_ctrl u_ctrl (
    .clk         (clk),
    .reset       (reset),
    .lane0       (lane[0]),
    .lane1       (lane[1]),
    .info0       (info[0]),
    .info1       (info[1]),
    .take0       (take0),
    .take1       (take1),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .slot0_valid (slot0_valid),
    .slot1_valid (slot1_valid),
    .slot0_inst  (slot0_inst),
    .slot1_inst  (slot1_inst),
    .slot0_pc    (slot0_pc),
    .slot1_pc    (slot1_pc),
    .slot0_id    (slot0_id),
    .slot1_id    (slot1_id),
    .swapped     (swapped)
  );

endmodule

// ==== testbench/tb_clock_gen.sv ====
module tb_clock_gen (
  output logic clk,
  output logic reset
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;           // 40 ns period.
  end

  initial begin
    reset = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// ==== testbench/issue_properties.sv ====
module issue_properties import issue_pkg::*; (
  input logic              clk,
  input logic              reset,
  input logic              issue_valid,
  input logic              issue_ready,
  input logic              slot0_valid,
  input logic              slot1_valid,
  input inst_u             slot0_inst,
  input inst_u             slot1_inst,
  input logic [ADDR_W-1:0] slot0_pc,
  input logic [ADDR_W-1:0] slot1_pc,
  input logic [ID_W-1:0]   slot0_id,
  input logic [ID_W-1:0]   slot1_id,
  input logic              swapped
);

  timeunit 1ns;
  timeprecision 100ps;

  // held bundle may not change.
  a_hold_stable: assert property (@(posedge clk) disable iff (reset)
    (issue_valid && !issue_ready) |=>
      ($stable(slot0_valid) && $stable(slot1_valid) && $stable(swapped) &&
       $stable(slot0_inst) && $stable(slot1_inst) && $stable(slot0_pc) &&
       $stable(slot1_pc) && $stable(slot0_id) && $stable(slot1_id)))
    else $error("issue outputs changed while held");

  // a valid slot carries a real instruction.
  a_slot0_inst: assert property (@(posedge clk) disable iff (reset)
    slot0_valid |-> (slot0_inst != NOP_WORD))
    else $error("valid slot 0 holds an empty word");

  a_slot1_inst: assert property (@(posedge clk) disable iff (reset)
    slot1_valid |-> (slot1_inst != NOP_WORD))
    else $error("valid slot 1 holds an empty word");

  a_swap_both: assert property (@(posedge clk)
    swapped |-> (slot0_valid && slot1_valid))
    else $error("swapped with a single slot");

  a_reset_idle: assert property (@(posedge clk) reset |=> !issue_valid)
    else $error("issue_valid high after reset");

endmodule

bind dual_issue_stage issue_properties u_props (.*);

// ==== testbench/tb_dual_issue.sv ====
module tb_dual_issue import issue_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic              clk;
  logic              reset;
  logic              in_valid;
  logic              in_ready;
  inst_u             in_inst0;
  inst_u             in_inst1;
  logic [ADDR_W-1:0] in_pc0;
  logic [ADDR_W-1:0] in_pc1;
  logic [ID_W-1:0]   in_id0;
  logic [ID_W-1:0]   in_id1;
  logic              ex_load_valid;
  logic [REG_W-1:0]  ex_load_rt;
  logic              issue_valid;
  logic              issue_ready;
  logic              slot0_valid;
  logic              slot1_valid;
  inst_u             slot0_inst;
  inst_u             slot1_inst;
  logic [ADDR_W-1:0] slot0_pc;
  logic [ADDR_W-1:0] slot1_pc;
  logic [ID_W-1:0]   slot0_id;
  logic [ID_W-1:0]   slot1_id;
  logic              swapped;

  // expected bundles, oldest first.
  logic              exp_v0 [$];
  logic              exp_v1 [$];
  logic              exp_sw [$];
  inst_u             exp_i0 [$];
  inst_u             exp_i1 [$];
  logic [ADDR_W-1:0] exp_p0 [$];
  logic [ADDR_W-1:0] exp_p1 [$];
  logic [ID_W-1:0]   exp_d0 [$];
  logic [ID_W-1:0]   exp_d1 [$];

  string             cur_test = "reset";
  integer            seed = 32'h37f1_95d9;
  logic [ADDR_W-1:0] next_pc = 32'h0000_1000;
  logic [ID_W-1:0]   next_id = '0;

  tb_clock_gen u_clk (.clk(clk), .reset(reset));

  dual_issue_stage UUT (.*);

  //////////////////////////////////////////////////////////////////////
  // failure reporting and compares
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic compare_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %b actual %b", cur_test, what, exp, act);
      abort_run("flag mismatch");
    end
  endtask

  task automatic compare_inst(input string what, input inst_u exp, input inst_u act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
      abort_run("instruction mismatch");
    end
  endtask

  task automatic compare_addr(input string what, input logic [ADDR_W-1:0] exp,
                              input logic [ADDR_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
      abort_run("pc mismatch");
    end
  endtask

  task automatic compare_id(input string what, input logic [ID_W-1:0] exp,
                            input logic [ID_W-1:0] act);
    if (act !== exp) begin
      $display("[ERROR] %s: %s expected %h actual %h", cur_test, what, exp, act);
      abort_run("id mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic void decode_ref(input inst_u w, output logic rs_u, output logic rt_u,
                                     output logic dv, output logic [REG_W-1:0] dr,
                                     output logic [PIPE_W-1:0] pipe);
    logic [OPC_W-1:0] op;
    op   = w.i_fmt.opcode;
    rs_u = 1'b0;
    rt_u = 1'b0;
    dv   = 1'b0;
    dr   = w.i_fmt.rt;
    pipe = PIPE_NONE;
    if (w == NOP_WORD) begin
      pipe = PIPE_NONE;
    end else if (op[5:4] == 2'b00) begin
      rs_u = 1'b1;
      rt_u = 1'b1;
      dv   = 1'b1;
      dr   = w.r_fmt.rd;
      pipe = (op == OPC_CMP || op == OPC_TEST) ? PIPE_BRANCH : PIPE_ALU;
    end else if (op[5:4] == 2'b01) begin
      rs_u = 1'b1;
      dv   = 1'b1;
      pipe = (op == OPC_CMPI || op == OPC_TESTI) ? PIPE_BRANCH : PIPE_ALU;
    end else if (op[5:4] == 2'b10) begin
      pipe = PIPE_MEMORY;
      rs_u = (op == OPC_LW || op == OPC_SW);
      rt_u = (op == OPC_SW || op == OPC_SA);
      dv   = (op == OPC_LW || op == OPC_LA);
    end else begin
      pipe = PIPE_BRANCH;
      rs_u = (op == OPC_JR);
    end
  endfunction

  task automatic push_bundle(input logic v0, input logic v1, input logic sw,
                             input inst_u i0, input logic [ADDR_W-1:0] p0,
                             input logic [ID_W-1:0] d0, input inst_u i1,
                             input logic [ADDR_W-1:0] p1, input logic [ID_W-1:0] d1);
    exp_v0.push_back(v0);
    exp_v1.push_back(v1);
    exp_sw.push_back(sw);
    exp_i0.push_back(i0);
    exp_p0.push_back(p0);
    exp_d0.push_back(d0);
    exp_i1.push_back(i1);
    exp_p1.push_back(p1);
    exp_d1.push_back(d1);
  endtask

  // memory unit lives in slot 1.
  task automatic push_lone(input inst_u i, input logic [ADDR_W-1:0] p,
                           input logic [ID_W-1:0] d, input logic [PIPE_W-1:0] pipe);
    if (pipe == PIPE_MEMORY) begin
      push_bundle(1'b0, 1'b1, 1'b0, NOP_WORD, '0, '0, i, p, d);
    end else begin
      push_bundle(1'b1, 1'b0, 1'b0, i, p, d, NOP_WORD, '0, '0);
    end
  endtask

  task automatic model_pair(input inst_u i0, input inst_u i1,
                            input logic [ADDR_W-1:0] p0, input logic [ADDR_W-1:0] p1,
                            input logic [ID_W-1:0] d0, input logic [ID_W-1:0] d1);
    logic              rs0, rt0, dv0, rs1, rt1, dv1;
    logic [REG_W-1:0]  dr0, dr1;
    logic [PIPE_W-1:0] pp0, pp1;
    logic              dep, conflict;
    decode_ref(i0, rs0, rt0, dv0, dr0, pp0);
    decode_ref(i1, rs1, rt1, dv1, dr1, pp1);
    dep = dv0 && ((rs1 && i1.i_fmt.rs == dr0) || (rt1 && i1.i_fmt.rt == dr0));
    conflict = (pp0 == pp1) && (pp0 == PIPE_BRANCH || pp0 == PIPE_MEMORY);
    if (i0 != NOP_WORD && i1 != NOP_WORD && !dep && !conflict) begin
      if (pp0 == PIPE_MEMORY || pp1 == PIPE_BRANCH) begin
        push_bundle(1'b1, 1'b1, 1'b1, i1, p1, d1, i0, p0, d0);
      end else begin
        push_bundle(1'b1, 1'b1, 1'b0, i0, p0, d0, i1, p1, d1);
      end
    end else begin
      if (i0 != NOP_WORD) push_lone(i0, p0, d0, pp0);
      if (i1 != NOP_WORD) push_lone(i1, p1, d1, pp1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // drivers and consumer
  //////////////////////////////////////////////////////////////////////

  function automatic inst_u mk_r(input logic [OPC_W-1:0] op, input logic [REG_W-1:0] rs,
                                 input logic [REG_W-1:0] rt, input logic [REG_W-1:0] rd);
    inst_u w;
    w = NOP_WORD;
    w.r_fmt.opcode = op;
    w.r_fmt.rs     = rs;
    w.r_fmt.rt     = rt;
    w.r_fmt.rd     = rd;
    return w;
  endfunction

  function automatic inst_u mk_i(input logic [OPC_W-1:0] op, input logic [REG_W-1:0] rs,
                                 input logic [REG_W-1:0] rt);
    inst_u w;
    w = NOP_WORD;
    w.i_fmt.opcode = op;
    w.i_fmt.rs     = rs;
    w.i_fmt.rt     = rt;
    w.i_fmt.imm    = 16'h0040;
    return w;
  endfunction

  // called on a falling edge, returns on one.
  task automatic send_pair(input inst_u i0, input inst_u i1);
    int waited;
    waited   = 0;
    in_valid = 1'b1;
    in_inst0 = i0;
    in_inst1 = i1;
    in_pc0   = next_pc;
    in_pc1   = next_pc + 4;
    in_id0   = next_id;
    in_id1   = next_id + 1'b1;
    while (!in_ready) begin
      @(negedge clk);
      waited++;
      if (waited > 200) abort_run("timeout waiting for in_ready");
    end
    model_pair(i0, i1, in_pc0, in_pc1, in_id0, in_id1);
    @(negedge clk);
    in_valid = 1'b0;
    next_pc  = next_pc + 8;
    next_id  = next_id + 2'd2;
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (exp_v0.size() != 0) begin
      @(negedge clk);
      waited++;
      if (waited > 200) abort_run("timeout waiting for expected bundles");
    end
  endtask

  always @(posedge clk) begin
    if (!reset && issue_valid && issue_ready) begin
      if (exp_v0.size() == 0) begin
        abort_run({"unexpected bundle issued in ", cur_test});
      end else begin
        compare_flag("slot0_valid", exp_v0[0], slot0_valid);
        compare_flag("slot1_valid", exp_v1[0], slot1_valid);
        compare_flag("swapped", exp_sw[0], swapped);
        if (exp_v0[0]) begin
          compare_inst("slot0_inst", exp_i0[0], slot0_inst);
          compare_addr("slot0_pc", exp_p0[0], slot0_pc);
          compare_id("slot0_id", exp_d0[0], slot0_id);
        end
        if (exp_v1[0]) begin
          compare_inst("slot1_inst", exp_i1[0], slot1_inst);
          compare_addr("slot1_pc", exp_p1[0], slot1_pc);
          compare_id("slot1_id", exp_d1[0], slot1_id);
        end
        void'(exp_v0.pop_front());
        void'(exp_v1.pop_front());
        void'(exp_sw.pop_front());
        void'(exp_i0.pop_front());
        void'(exp_p0.pop_front());
        void'(exp_d0.pop_front());
        void'(exp_i1.pop_front());
        void'(exp_p1.pop_front());
        void'(exp_d1.pop_front());
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_alu_pairs();
    int i;
    cur_test = "alu_pairs";
    for (i = 0; i < 4; i++) begin
      send_pair(mk_r(6'b000100, 5'd1, 5'd2, 5'(3 + i)), mk_r(6'b000100, 5'd8, 5'd9, 5'd20));
    end
    send_pair(NOP_WORD, NOP_WORD);      // accepted, issues nothing.
    wait_drain();
  endtask

  task automatic test_steering();
    cur_test = "steering";
    send_pair(mk_i(OPC_LW, 5'd6, 5'd5), mk_r(6'b000100, 5'd8, 5'd9, 5'd7));
    send_pair(mk_r(6'b000100, 5'd2, 5'd3, 5'd1), mk_i(OPC_JR, 5'd4, 5'd0));
    send_pair(mk_r(OPC_CMP, 5'd11, 5'd12, 5'd10), mk_i(OPC_SW, 5'd13, 5'd14));
    wait_drain();
  endtask

  task automatic test_dependency();
    int i;
    logic [31:0] r;
    cur_test = "dependency";
    for (i = 0; i < 12; i++) begin
      r = $random(seed);
      if (i % 2 == 0) begin
        send_pair(mk_r(6'b000100, 5'(r[5:3]), 5'(r[8:6]), 5'(r[2:0])),
                  mk_r(6'b000110, 5'(r[11:9]), 5'(r[14:12]), 5'(r[17:15])));
      end else begin
        send_pair(mk_r(6'b000100, 5'(r[5:3]), 5'(r[8:6]), 5'(r[2:0])),
                  mk_i(6'b010100, 5'(r[11:9]), 5'(r[14:12])));   // immediate add.
      end
    end
    wait_drain();
  endtask

  task automatic test_conflicts();
    cur_test = "conflicts";
    send_pair(mk_r(OPC_CMP, 5'd2, 5'd3, 5'd1), mk_i(OPC_JR, 5'd4, 5'd0));
    send_pair(mk_i(OPC_LW, 5'd2, 5'd6), mk_i(OPC_SA, 5'd0, 5'd7));
    send_pair(mk_i(OPC_SW, 5'd1, 5'd2), mk_i(OPC_LA, 5'd0, 5'd3));
    wait_drain();
  endtask

  task automatic test_load_use();
    int i;
    cur_test = "load_use";
    ex_load_valid = 1'b1;
    ex_load_rt    = 5'd12;
    send_pair(mk_r(6'b000100, 5'd12, 5'd1, 5'd13), mk_r(6'b000100, 5'd2, 5'd3, 5'd14));
    for (i = 0; i < 20; i++) begin
      if (issue_valid) abort_run("bundle issued during a load-use hazard");
      @(negedge clk);
    end
    ex_load_valid = 1'b0;
    wait_drain();
  endtask

  task automatic test_back_pressure();
    int    i;
    logic  dropped;
    inst_u held0;
    inst_u held1;
    logic [ID_W-1:0] held_id;
    cur_test    = "back_pressure";
    dropped     = 1'b0;
    issue_ready = 1'b0;
    for (i = 0; i < 8 && !dropped; i++) begin
      if (!in_ready) begin
        dropped = 1'b1;
      end else begin
        send_pair(mk_r(6'b000100, 5'd1, 5'd2, 5'(16 + i)), mk_i(6'b010100, 5'd3, 5'd4));
      end
    end
    if (!dropped) abort_run("in_ready never dropped under back-pressure");
    compare_flag("issue_valid", 1'b1, issue_valid);
    held0   = slot0_inst;
    held1   = slot1_inst;
    held_id = slot0_id;
    repeat (10) begin
      @(negedge clk);
      compare_inst("held slot0_inst", held0, slot0_inst);
      compare_inst("held slot1_inst", held1, slot1_inst);
      compare_id("held slot0_id", held_id, slot0_id);
    end
    issue_ready = 1'b1;
    send_pair(mk_r(6'b000100, 5'd5, 5'd6, 5'd30), mk_i(6'b010100, 5'd7, 5'd31));
    wait_drain();
  endtask

  initial begin
    int waited;
    in_valid      = 1'b0;
    in_inst0      = NOP_WORD;
    in_inst1      = NOP_WORD;
    in_pc0        = '0;
    in_pc1        = '0;
    in_id0        = '0;
    in_id1        = '0;
    ex_load_valid = 1'b0;
    ex_load_rt    = '0;
    issue_ready   = 1'b1;
    waited        = 0;
    @(posedge clk);
    while (reset) begin
      @(posedge clk);
      waited++;
      if (waited > 200) abort_run("reset never released");
    end
    @(negedge clk);
    test_alu_pairs();
    test_steering();
    test_dependency();
    test_conflicts();
    test_load_use();
    test_back_pressure();
    repeat (4) @(negedge clk);
    if (exp_v0.size() == 0 && !issue_valid) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("%0d expected bundles never issued", exp_v0.size());
      $display("Test failed");
      $fatal(1, "simulation stopped on error");
    end
  end

endmodule

// ==== all.f ====
hdl/issue_pkg.sv
hdl/issue_if.sv
hdl/pair_fetch_queue.sv
hdl/lane_decoder.sv
hdl/pair_issue_ctrl.sv
hdl/dual_issue_stage.sv
testbench/tb_clock_gen.sv
testbench/issue_properties.sv
testbench/tb_dual_issue.sv

// ==== Bender.yml ====
package:
  name: dual_issue_stage

sources:
  - files:
      - hdl/issue_pkg.sv
      - hdl/issue_if.sv
      - hdl/pair_fetch_queue.sv
      - hdl/lane_decoder.sv
      - hdl/pair_issue_ctrl.sv
      - hdl/dual_issue_stage.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/issue_properties.sv
      - testbench/tb_dual_issue.sv
